/* include/id_defs.svh */
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// datapath and register file sizes
`define ID_XLEN        32
`define ID_RADDR_W     5
`define ID_NREGS       32
`define ID_LINK_REG    5'd31

// one-hot alu operation field
`define ID_ALU_OP_W    9
`define ID_ALU_ADD     0
`define ID_ALU_SUB     1
`define ID_ALU_SLT     2
`define ID_ALU_SLTU    3
`define ID_ALU_AND     4
`define ID_ALU_OR      5
`define ID_ALU_XOR     6
`define ID_ALU_NOR     7
`define ID_ALU_LUI     8

// primary opcodes
`define ID_OP_SPECIAL  6'h00
`define ID_OP_J        6'h02
`define ID_OP_JAL      6'h03
`define ID_OP_BEQ      6'h04
`define ID_OP_BNE      6'h05
`define ID_OP_ADDIU    6'h09
`define ID_OP_LUI      6'h0f
`define ID_OP_LW       6'h23
`define ID_OP_SW       6'h2b

// function codes under SPECIAL
`define ID_FN_JR       6'h08
`define ID_FN_ADDU     6'h21
`define ID_FN_SUBU     6'h23
`define ID_FN_AND      6'h24
`define ID_FN_OR       6'h25
`define ID_FN_XOR      6'h26
`define ID_FN_NOR      6'h27
`define ID_FN_SLT      6'h2a
`define ID_FN_SLTU     6'h2b

`endif

/* rtl/id_pkg.sv */
`default_nettype none

`include "id_defs.svh"

package id_pkg;

    // register-format view
    typedef struct packed {
        logic [5:0]             op;
        logic [`ID_RADDR_W-1:0] rs;
        logic [`ID_RADDR_W-1:0] rt;
        logic [`ID_RADDR_W-1:0] rd;
        logic [`ID_RADDR_W-1:0] sa;
        logic [5:0]             funct;
    } r_view_t;

    // immediate-format fields below the opcode
    typedef struct packed {
        logic [`ID_RADDR_W-1:0] rs;
        logic [`ID_RADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_fields_t;

    // the same 26 bits read as a jump index
    typedef union packed {
        i_fields_t   i;
        logic [25:0] jidx;
    } ij_arg_t;

    typedef struct packed {
        logic [5:0] op;
        ij_arg_t    arg;
    } ij_view_t;

    typedef union packed {
        r_view_t  r;
        ij_view_t ij;
    } inst_word_t;

endpackage

`default_nettype wire

/* rtl/bypass_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

// pending register result of one later pipeline stage
interface bypass_if;

    logic                   valid;
    logic [`ID_RADDR_W-1:0] dest;
    logic [`ID_XLEN-1:0]    result;
    // low while a load in execute has no data yet
    logic                   ready;

    modport source (
        output valid,
        output dest,
        output result,
        output ready
    );

    modport sink (
        input valid,
        input dest,
        input result,
        input ready
    );

endinterface

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module inst_decoder
    import id_pkg::*;
(
    input  inst_word_t                inst,
    output logic [`ID_ALU_OP_W-1:0]   alu_op,
    output logic                      src1_is_pc,
    output logic                      src2_is_imm,
    output logic                      src2_is_8,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      gr_we,
    output logic [`ID_RADDR_W-1:0]    dest,
    output logic [15:0]               imm,
    output logic                      uses_rs,
    output logic                      uses_rt,
    output logic                      is_branch,
    output logic                      is_jump_reg,
    output logic                      is_jump_imm
);

    logic special;
    logic sa_zero;
    logic inst_addu;
    logic inst_subu;
    logic inst_slt;
    logic inst_sltu;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_nor;
    logic inst_jr;
    logic inst_addiu;
    logic inst_lui;
    logic inst_lw;
    logic inst_sw;
    logic inst_beq;
    logic inst_bne;
    logic inst_j;
    logic inst_jal;
    logic r_alu;
    logic dst_is_rt;

    assign special = inst.r.op == `ID_OP_SPECIAL;
    assign sa_zero = inst.r.sa == '0;

    // register-format ops
    assign inst_addu = special && sa_zero && inst.r.funct == `ID_FN_ADDU;
    assign inst_subu = special && sa_zero && inst.r.funct == `ID_FN_SUBU;
    assign inst_slt  = special && sa_zero && inst.r.funct == `ID_FN_SLT;
    assign inst_sltu = special && sa_zero && inst.r.funct == `ID_FN_SLTU;
    assign inst_and  = special && sa_zero && inst.r.funct == `ID_FN_AND;
    assign inst_or   = special && sa_zero && inst.r.funct == `ID_FN_OR;
    assign inst_xor  = special && sa_zero && inst.r.funct == `ID_FN_XOR;
    assign inst_nor  = special && sa_zero && inst.r.funct == `ID_FN_NOR;
    assign inst_jr   = special && sa_zero && inst.r.funct == `ID_FN_JR
                       && inst.r.rt == '0 && inst.r.rd == '0;

    // immediate and jump formats
    assign inst_addiu = inst.ij.op == `ID_OP_ADDIU;
    assign inst_lui   = inst.ij.op == `ID_OP_LUI && inst.ij.arg.i.rs == '0;
    assign inst_lw    = inst.ij.op == `ID_OP_LW;
    assign inst_sw    = inst.ij.op == `ID_OP_SW;
    assign inst_beq   = inst.ij.op == `ID_OP_BEQ;
    assign inst_bne   = inst.ij.op == `ID_OP_BNE;
    assign inst_j     = inst.ij.op == `ID_OP_J;
    assign inst_jal   = inst.ij.op == `ID_OP_JAL;

    assign r_alu = inst_addu | inst_subu | inst_slt | inst_sltu
                 | inst_and | inst_or | inst_xor | inst_nor;

    // jal computes pc + 8 on the adder
    assign alu_op[`ID_ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
    assign alu_op[`ID_ALU_SUB]  = inst_subu;
    assign alu_op[`ID_ALU_SLT]  = inst_slt;
    assign alu_op[`ID_ALU_SLTU] = inst_sltu;
    assign alu_op[`ID_ALU_AND]  = inst_and;
    assign alu_op[`ID_ALU_OR]   = inst_or;
    assign alu_op[`ID_ALU_XOR]  = inst_xor;
    assign alu_op[`ID_ALU_NOR]  = inst_nor;
    assign alu_op[`ID_ALU_LUI]  = inst_lui;

    assign src1_is_pc  = inst_jal;
    assign src2_is_8   = inst_jal;
    assign src2_is_imm = inst_addiu | inst_lui | inst_lw | inst_sw;
    assign mem_read    = inst_lw;
    assign mem_write   = inst_sw;
    assign gr_we       = r_alu | inst_addiu | inst_lui | inst_lw | inst_jal;

    assign dst_is_rt = inst_addiu | inst_lui | inst_lw;
    assign dest = inst_jal  ? `ID_LINK_REG :
                  dst_is_rt ? inst.ij.arg.i.rt :
                              inst.r.rd;
    assign imm  = inst.ij.arg.i.imm;

    // only real source fields may cause an interlock
    assign uses_rs = r_alu | inst_addiu | inst_lw | inst_sw | inst_beq | inst_bne | inst_jr;
    assign uses_rt = r_alu | inst_sw | inst_beq | inst_bne;

    assign is_branch   = inst_beq | inst_bne;
    assign is_jump_reg = inst_jr;
    assign is_jump_imm = inst_j | inst_jal;

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module reg_file (
    input  logic                   clk,
    input  logic [`ID_RADDR_W-1:0] raddr1,
    input  logic [`ID_RADDR_W-1:0] raddr2,
    input  logic                   we,
    input  logic [`ID_RADDR_W-1:0] waddr,
    input  logic [`ID_XLEN-1:0]    wdata,
    output logic [`ID_XLEN-1:0]    rdata1,
    output logic [`ID_XLEN-1:0]    rdata2
);

    logic [`ID_XLEN-1:0] regs [`ID_NREGS];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through for a same-cycle write
    function automatic logic [`ID_XLEN-1:0] read_port(input logic [`ID_RADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

`default_nettype wire

/* rtl/operand_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module operand_bypass (
    input  logic [`ID_RADDR_W-1:0] rs,
    input  logic [`ID_RADDR_W-1:0] rt,
    input  logic                   uses_rs,
    input  logic                   uses_rt,
    input  logic [`ID_XLEN-1:0]    rf_rs,
    input  logic [`ID_XLEN-1:0]    rf_rt,
    bypass_if.sink                 es_byp,
    bypass_if.sink                 ms_byp,
    output logic [`ID_XLEN-1:0]    rs_value,
    output logic [`ID_XLEN-1:0]    rt_value,
    output logic                   blocked
);

    logic rs_es_hit;
    logic rs_ms_hit;
    logic rt_es_hit;
    logic rt_ms_hit;
    logic rs_wait;
    logic rt_wait;

    // r0 always reads zero, so it never matches
    function automatic logic hit(
        input logic                   use_src,
        input logic [`ID_RADDR_W-1:0] src,
        input logic                   byp_valid,
        input logic [`ID_RADDR_W-1:0] byp_dest
    );
        return use_src && src != '0 && byp_valid && src == byp_dest;
    endfunction

    assign rs_es_hit = hit(uses_rs, rs, es_byp.valid, es_byp.dest);
    assign rs_ms_hit = hit(uses_rs, rs, ms_byp.valid, ms_byp.dest);
    assign rt_es_hit = hit(uses_rt, rt, es_byp.valid, es_byp.dest);
    assign rt_ms_hit = hit(uses_rt, rt, ms_byp.valid, ms_byp.dest);

    // youngest producer wins
    assign rs_value = rs_es_hit ? es_byp.result :
                      rs_ms_hit ? ms_byp.result :
                                  rf_rs;
    assign rt_value = rt_es_hit ? es_byp.result :
                      rt_ms_hit ? ms_byp.result :
                                  rf_rt;

    // stall only on the match that would be selected
    assign rs_wait = rs_es_hit ? !es_byp.ready : (rs_ms_hit && !ms_byp.ready);
    assign rt_wait = rt_es_hit ? !es_byp.ready : (rt_ms_hit && !ms_byp.ready);
    assign blocked = rs_wait || rt_wait;

endmodule

`default_nettype wire

/* rtl/branch_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module branch_resolve
    import id_pkg::*;
(
    input  inst_word_t             inst,
    input  logic [`ID_XLEN-1:0]    pc,
    input  logic                   ds_valid,
    input  logic                   blocked,
    input  logic                   is_branch,
    input  logic                   is_jump_reg,
    input  logic                   is_jump_imm,
    input  logic [`ID_XLEN-1:0]    rs_value,
    input  logic [`ID_XLEN-1:0]    rt_value,
    output logic                   br_valid,
    output logic                   br_stall,
    output logic                   br_taken,
    output logic [`ID_XLEN-1:0]    br_target
);

    logic [`ID_XLEN-1:0] bd_pc;
    logic [`ID_XLEN-1:0] br_offset;
    logic                rs_eq_rt;
    logic                cond_ok;

    // delay-slot pc
    assign bd_pc     = pc + `ID_XLEN'd4;
    assign br_offset = {{(`ID_XLEN-18){inst.ij.arg.i.imm[15]}}, inst.ij.arg.i.imm, 2'b00};
    assign rs_eq_rt  = rs_value == rt_value;

    // beq and bne differ only in the sense of the compare
    assign cond_ok = (inst.ij.op == `ID_OP_BEQ &&  rs_eq_rt)
                  || (inst.ij.op == `ID_OP_BNE && !rs_eq_rt);

    assign br_valid = ds_valid && (is_branch || is_jump_reg || is_jump_imm);
    assign br_stall = ds_valid && blocked && (is_branch || is_jump_reg);
    assign br_taken = ds_valid && ((is_branch && cond_ok) || is_jump_reg || is_jump_imm);

    assign br_target = is_branch   ? bd_pc + br_offset :
                       is_jump_reg ? rs_value :
                       is_jump_imm ? {bd_pc[`ID_XLEN-1 -: 4], inst.ij.arg.jidx, 2'b00} :
                                     '0;

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_stage
    import id_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fs_valid,
    input  logic [`ID_XLEN-1:0]     fs_inst,
    input  logic [`ID_XLEN-1:0]     fs_pc,
    input  logic                    es_allowin,
    input  logic                    es_valid,
    input  logic [`ID_RADDR_W-1:0]  es_dest,
    input  logic [`ID_XLEN-1:0]     es_result,
    input  logic                    es_ready,
    input  logic                    ms_valid,
    input  logic [`ID_RADDR_W-1:0]  ms_dest,
    input  logic [`ID_XLEN-1:0]     ms_result,
    input  logic                    ms_ready,
    input  logic                    ws_we,
    input  logic [`ID_RADDR_W-1:0]  ws_waddr,
    input  logic [`ID_XLEN-1:0]     ws_wdata,
    output logic                    ds_allowin,
    output logic                    ds_to_es_valid,
    output logic [`ID_ALU_OP_W-1:0] alu_op,
    output logic                    src1_is_pc,
    output logic                    src2_is_imm,
    output logic                    src2_is_8,
    output logic                    mem_read,
    output logic                    mem_write,
    output logic                    gr_we,
    output logic [`ID_RADDR_W-1:0]  dest,
    output logic [15:0]             imm,
    output logic [`ID_XLEN-1:0]     rs_value,
    output logic [`ID_XLEN-1:0]     rt_value,
    output logic [`ID_XLEN-1:0]     ds_pc,
    output logic                    br_valid,
    output logic                    br_stall,
    output logic                    br_taken,
    output logic [`ID_XLEN-1:0]     br_target
);

    logic                ds_valid;
    inst_word_t          ds_inst;
    logic                uses_rs;
    logic                uses_rt;
    logic                is_branch;
    logic                is_jump_reg;
    logic                is_jump_imm;
    logic [`ID_XLEN-1:0] rf_rs;
    logic [`ID_XLEN-1:0] rf_rt;
    logic                blocked;

    bypass_if es_byp ();
    bypass_if ms_byp ();

    assign es_byp.valid  = es_valid;
    assign es_byp.dest   = es_dest;
    assign es_byp.result = es_result;
    assign es_byp.ready  = es_ready;
    assign ms_byp.valid  = ms_valid;
    assign ms_byp.dest   = ms_dest;
    assign ms_byp.result = ms_result;
    assign ms_byp.ready  = ms_ready;

    // handshake
    assign ds_allowin     = !ds_valid || (!blocked && es_allowin);
    assign ds_to_es_valid = ds_valid && !blocked;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder i_inst_decoder (
        .inst        (ds_inst),
        .alu_op      (alu_op),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .src2_is_8   (src2_is_8),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .gr_we       (gr_we),
        .dest        (dest),
        .imm         (imm),
        .uses_rs     (uses_rs),
        .uses_rt     (uses_rt),
        .is_branch   (is_branch),
        .is_jump_reg (is_jump_reg),
        .is_jump_imm (is_jump_imm)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .raddr1 (ds_inst.r.rs),
        .raddr2 (ds_inst.r.rt),
        .we     (ws_we),
        .waddr  (ws_waddr),
        .wdata  (ws_wdata),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt)
    );

    operand_bypass i_operand_bypass (
        .rs       (ds_inst.r.rs),
        .rt       (ds_inst.r.rt),
        .uses_rs  (uses_rs),
        .uses_rt  (uses_rt),
        .rf_rs    (rf_rs),
        .rf_rt    (rf_rt),
        .es_byp   (es_byp),
        .ms_byp   (ms_byp),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .blocked  (blocked)
    );

    branch_resolve i_branch_resolve (
        .inst        (ds_inst),
        .pc          (ds_pc),
        .ds_valid    (ds_valid),
        .blocked     (blocked),
        .is_branch   (is_branch),
        .is_jump_reg (is_jump_reg),
        .is_jump_imm (is_jump_imm),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .br_valid    (br_valid),
        .br_stall    (br_stall),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

endmodule

`default_nettype wire

/* tb/id_stage_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_stage_assert (
    input logic                    clk,
    input logic                    reset,
    input logic                    es_allowin,
    input logic                    ds_valid,
    input logic                    uses_rs,
    input logic [`ID_RADDR_W-1:0]  rs,
    input logic                    es_valid,
    input logic [`ID_RADDR_W-1:0]  es_dest,
    input logic                    es_ready,
    input logic                    ds_allowin,
    input logic                    ds_to_es_valid,
    input logic                    br_valid,
    input logic                    br_taken,
    input logic [`ID_ALU_OP_W-1:0] alu_op,
    input logic [`ID_RADDR_W-1:0]  dest,
    input logic [15:0]             imm,
    input logic [`ID_XLEN-1:0]     ds_pc
);

    // execute stalled, so the held instruction must not move
    held_stable: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=>
            $stable(ds_pc) && $stable(alu_op) && $stable(dest) && $stable(imm))
    else $error("decoded outputs changed under back-pressure");

    // rs waiting on a load still in execute
    load_use_hold: assert property (@(posedge clk) disable iff (reset)
        ds_valid && uses_rs && rs != '0 && es_valid && es_dest == rs && !es_ready
            |-> !ds_to_es_valid && !ds_allowin)
    else $error("instruction passed on while its rs waits for a load");

    // stage is empty right after reset
    reset_values: assert property (@(posedge clk)
        $past(reset) |-> !ds_to_es_valid && !br_valid && !br_taken && ds_allowin)
    else $error("wrong output values after reset");

endmodule

bind id_stage id_stage_assert i_id_stage_assert (
    .clk            (clk),
    .reset          (reset),
    .es_allowin     (es_allowin),
    .ds_valid       (ds_valid),
    .uses_rs        (uses_rs),
    .rs             (ds_inst.r.rs),
    .es_valid       (es_valid),
    .es_dest        (es_dest),
    .es_ready       (es_ready),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .br_valid       (br_valid),
    .br_taken       (br_taken),
    .alu_op         (alu_op),
    .dest           (dest),
    .imm            (imm),
    .ds_pc          (ds_pc)
);

`default_nettype wire

/* tb/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module tb_id_stage;

    localparam int timeout_cycles = 20;

    logic                    clk;
    logic                    reset;
    logic                    fs_valid;
    logic [`ID_XLEN-1:0]     fs_inst;
    logic [`ID_XLEN-1:0]     fs_pc;
    logic                    es_allowin;
    logic                    es_valid;
    logic [`ID_RADDR_W-1:0]  es_dest;
    logic [`ID_XLEN-1:0]     es_result;
    logic                    es_ready;
    logic                    ms_valid;
    logic [`ID_RADDR_W-1:0]  ms_dest;
    logic [`ID_XLEN-1:0]     ms_result;
    logic                    ms_ready;
    logic                    ws_we;
    logic [`ID_RADDR_W-1:0]  ws_waddr;
    logic [`ID_XLEN-1:0]     ws_wdata;
    logic                    ds_allowin;
    logic                    ds_to_es_valid;
    logic [`ID_ALU_OP_W-1:0] alu_op;
    logic                    src1_is_pc;
    logic                    src2_is_imm;
    logic                    src2_is_8;
    logic                    mem_read;
    logic                    mem_write;
    logic                    gr_we;
    logic [`ID_RADDR_W-1:0]  dest;
    logic [15:0]             imm;
    logic [`ID_XLEN-1:0]     rs_value;
    logic [`ID_XLEN-1:0]     rt_value;
    logic [`ID_XLEN-1:0]     ds_pc;
    logic                    br_valid;
    logic                    br_stall;
    logic                    br_taken;
    logic [`ID_XLEN-1:0]     br_target;

    logic [31:0] model_regs [`ID_NREGS];
    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          errors_before;

    id_stage i_id_stage (.*);

    always #50 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_format(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [5:0] fn);
        return {`ID_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] val);
        return {op, rs, rt, val};
    endfunction

    function automatic logic [31:0] j_format(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        ws_we    = 1'b1;
        ws_waddr = addr;
        ws_wdata = data;
        @(negedge clk);
        ws_we = 1'b0;
        if (addr != 5'd0) begin
            model_regs[addr] = data;
        end
    endtask

    // returns in the decode cycle of the instruction, after the outputs settle
    task automatic send(input logic [31:0] inst, input logic [31:0] pc);
        int waited;
        waited = 0;
        @(negedge clk);
        fs_valid = 1'b1;
        fs_inst  = inst;
        fs_pc    = pc;
        #1;
        while (!ds_allowin && waited < timeout_cycles) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!ds_allowin) begin
            errors++;
            $display("timeout: stage never accepted instruction %h", inst);
        end
        @(negedge clk);
        fs_valid = 1'b0;
        #20;
    endtask

    task automatic wait_issue();
        int waited;
        waited = 0;
        while (!ds_to_es_valid && waited < timeout_cycles) begin
            @(negedge clk);
            #20;
            waited++;
        end
        if (!ds_to_es_valid) begin
            errors++;
            $display("timeout: held instruction was never passed to execute");
        end
    endtask

    task automatic alu_case(input logic [31:0] inst, input int op_bit,
                            input logic [4:0] exp_dest, input logic exp_imm,
                            input logic [4:0] rs, input logic [4:0] rt, input logic use_rt);
        send(inst, random_bits(32) & ~32'h3);
        check("ds_to_es_valid", 32'(ds_to_es_valid), 1);
        check("alu_op", 32'(alu_op), 32'(1) << op_bit);
        check("dest", 32'(dest), 32'(exp_dest));
        check("gr_we", 32'(gr_we), 1);
        check("src2_is_imm", 32'(src2_is_imm), 32'(exp_imm));
        check("rs_value", rs_value, model_regs[rs]);
        if (use_rt) begin
            check("rt_value", rt_value, model_regs[rt]);
        end
        if (exp_imm) begin
            check("imm", 32'(imm), 32'(inst[15:0]));
        end
    endtask

    task automatic branch_case(input logic [5:0] op, input logic [4:0] rt,
                               input logic exp_taken);
        logic [15:0] off;
        logic [31:0] pc;
        off = 16'(random_bits(16));
        pc  = random_bits(32) & ~32'h3;
        send(i_format(op, 5'd10, rt, off), pc);
        check("br_valid", 32'(br_valid), 1);
        check("br_taken", 32'(br_taken), 32'(exp_taken));
        check("br_target", br_target, pc + 32'd4 + {{14{off[15]}}, off, 2'b00});
    endtask

    initial begin
        logic [4:0]  rs_sel;
        logic [4:0]  rt_sel;
        logic [4:0]  rd_sel;
        logic [15:0] imm_sel;
        logic [25:0] idx;
        logic [31:0] v;
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        lfsr_state    = 32'h94982ff5;
        checks        = 0;
        errors        = 0;
        errors_before = 0;
        clk        = 1'b0;
        reset      = 1'b1;
        fs_valid   = 1'b0;
        fs_inst    = '0;
        fs_pc      = '0;
        es_allowin = 1'b1;
        es_valid   = 1'b0;
        es_dest    = '0;
        es_result  = '0;
        es_ready   = 1'b1;
        ms_valid   = 1'b0;
        ms_dest    = '0;
        ms_result  = '0;
        ms_ready   = 1'b1;
        ws_we      = 1'b0;
        ws_waddr   = '0;
        ws_wdata   = '0;
        for (int r = 0; r < `ID_NREGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // alu decode and plain register reads, r0 written too
        for (int r = 0; r < `ID_NREGS; r++) begin
            write_reg(5'(r), random_bits(32));
        end
        rs_sel  = 5'(random_bits(5));
        rt_sel  = 5'(random_bits(5));
        rd_sel  = 5'(random_bits(5));
        imm_sel = 16'(random_bits(16));
        alu_case(r_format(rs_sel, rt_sel, rd_sel, `ID_FN_ADDU), `ID_ALU_ADD, rd_sel, 1'b0,
                 rs_sel, rt_sel, 1'b1);
        alu_case(r_format(rs_sel, rt_sel, rd_sel, `ID_FN_SLT), `ID_ALU_SLT, rd_sel, 1'b0,
                 rs_sel, rt_sel, 1'b1);
        alu_case(r_format(rs_sel, rt_sel, rd_sel, `ID_FN_NOR), `ID_ALU_NOR, rd_sel, 1'b0,
                 rs_sel, rt_sel, 1'b1);
        alu_case(i_format(`ID_OP_ADDIU, rs_sel, rt_sel, imm_sel), `ID_ALU_ADD, rt_sel, 1'b1,
                 rs_sel, rt_sel, 1'b0);
        alu_case(i_format(`ID_OP_LUI, 5'd0, rt_sel, imm_sel), `ID_ALU_LUI, rt_sel, 1'b1,
                 5'd0, rt_sel, 1'b0);
        alu_case(r_format(5'd0, rt_sel, rd_sel, `ID_FN_ADDU), `ID_ALU_ADD, rd_sel, 1'b0,
                 5'd0, rt_sel, 1'b1);
        end_test("alu_decode");

        // same register pending everywhere, instruction held by execute
        @(negedge clk);
        es_allowin = 1'b0;
        es_valid   = 1'b1;
        es_dest    = 5'd9;
        es_result  = random_bits(32);
        ms_valid   = 1'b1;
        ms_dest    = 5'd9;
        ms_result  = random_bits(32);
        ws_we      = 1'b1;
        ws_waddr   = 5'd9;
        ws_wdata   = random_bits(32);
        send(r_format(5'd9, 5'd0, 5'd2, `ID_FN_ADDU), 32'h0000_1000);
        check("rs_value", rs_value, es_result);
        @(negedge clk);
        es_valid = 1'b0;
        #20;
        check("rs_value", rs_value, ms_result);
        @(negedge clk);
        ms_valid = 1'b0;
        // new data not yet stored, only the write-through path has it
        ws_wdata = random_bits(32);
        #20;
        check("rs_value", rs_value, ws_wdata);
        @(negedge clk);
        ws_we      = 1'b0;
        es_allowin = 1'b1;
        model_regs[9] = ws_wdata;
        end_test("bypass_priority");

        // load in execute feeding rs
        @(negedge clk);
        es_valid  = 1'b1;
        es_dest   = 5'd7;
        es_result = random_bits(32);
        es_ready  = 1'b0;
        send(r_format(5'd7, 5'd8, 5'd4, `ID_FN_ADDU), 32'h0000_2000);
        repeat (3) begin
            check("ds_to_es_valid", 32'(ds_to_es_valid), 0);
            check("ds_allowin", 32'(ds_allowin), 0);
            @(negedge clk);
            #20;
        end
        @(negedge clk);
        es_ready = 1'b1;
        #20;
        wait_issue();
        check("rs_value", rs_value, es_result);
        check("rt_value", rt_value, model_regs[8]);
        @(negedge clk);
        es_valid = 1'b0;
        end_test("load_use");

        v = random_bits(32);
        write_reg(5'd10, v);
        write_reg(5'd11, v);
        write_reg(5'd12, v ^ (random_bits(32) | 32'd1));
        branch_case(`ID_OP_BEQ, 5'd11, 1'b1);
        branch_case(`ID_OP_BEQ, 5'd12, 1'b0);
        branch_case(`ID_OP_BNE, 5'd11, 1'b0);
        branch_case(`ID_OP_BNE, 5'd12, 1'b1);
        end_test("branches");

        idx  = 26'(random_bits(26));
        pc_a = random_bits(32) & ~32'h3;
        pc_b = pc_a + 32'd4;
        send(j_format(`ID_OP_JAL, idx), pc_a);
        check("dest", 32'(dest), 31);
        check("src1_is_pc", 32'(src1_is_pc), 1);
        check("src2_is_8", 32'(src2_is_8), 1);
        check("gr_we", 32'(gr_we), 1);
        check("br_taken", 32'(br_taken), 1);
        check("br_target", br_target, {pc_b[31:28], idx, 2'b00});
        send(r_format(5'd13, 5'd0, 5'd0, `ID_FN_JR), pc_a);
        check("br_taken", 32'(br_taken), 1);
        check("br_stall", 32'(br_stall), 0);
        check("br_target", br_target, model_regs[13]);
        // jr waiting on a load for its target
        @(negedge clk);
        es_valid  = 1'b1;
        es_dest   = 5'd13;
        es_result = random_bits(32);
        es_ready  = 1'b0;
        send(r_format(5'd13, 5'd0, 5'd0, `ID_FN_JR), pc_a);
        check("br_stall", 32'(br_stall), 1);
        check("ds_to_es_valid", 32'(ds_to_es_valid), 0);
        @(negedge clk);
        es_ready = 1'b1;
        #20;
        wait_issue();
        check("br_stall", 32'(br_stall), 0);
        check("br_target", br_target, es_result);
        @(negedge clk);
        es_valid = 1'b0;
        end_test("jumps");

        imm_sel = 16'(random_bits(16));
        send(i_format(`ID_OP_LW, 5'd20, 5'd21, imm_sel), 32'h0000_3000);
        check("mem_read", 32'(mem_read), 1);
        check("mem_write", 32'(mem_write), 0);
        check("gr_we", 32'(gr_we), 1);
        check("dest", 32'(dest), 21);
        send(i_format(`ID_OP_SW, 5'd20, 5'd21, imm_sel), 32'h0000_3004);
        check("mem_read", 32'(mem_read), 0);
        check("mem_write", 32'(mem_write), 1);
        check("gr_we", 32'(gr_we), 0);
        @(negedge clk);
        es_allowin = 1'b0;
        pc_a = 32'h0000_4000;
        pc_b = 32'h0000_4004;
        send(i_format(`ID_OP_LW, 5'd20, 5'd21, imm_sel), pc_a);
        @(negedge clk);
        fs_valid = 1'b1;
        fs_inst  = r_format(5'd1, 5'd2, 5'd3, `ID_FN_ADDU);
        fs_pc    = pc_b;
        repeat (3) begin
            #20;
            check("ds_allowin", 32'(ds_allowin), 0);
            check("ds_pc", ds_pc, pc_a);
            @(negedge clk);
        end
        es_allowin = 1'b1;
        @(negedge clk);
        fs_valid = 1'b0;
        #20;
        check("ds_pc", ds_pc, pc_b);
        check("alu_op", 32'(alu_op), 32'(1) << `ID_ALU_ADD);
        check("ds_to_es_valid", 32'(ds_to_es_valid), 1);
        end_test("mem_backpressure");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
rtl/id_pkg.sv
rtl/bypass_if.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/operand_bypass.sv
rtl/branch_resolve.sv
rtl/id_stage.sv
tb/id_stage_assert.sv
tb/tb_id_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_id_stage -f sim.f -o tb_id_stage

out=$(./obj_dir/tb_id_stage 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
